// ==== orbit_pkg.sv ====
package orbit_pkg;

    // ========================================================================
    // Shared widths
    // ========================================================================
    localparam int ANGLE_W = 8;
    localparam int TRIG_W  = 8;
    localparam int COORD_W = 10;

    // One full turn of the orbit is 2**ANGLE_W steps
    typedef logic [ANGLE_W-1:0] angle_t;

    // Sine or cosine, unsigned with zero at TRIG_ZERO
    typedef logic [TRIG_W-1:0] trig_t;

    typedef logic [COORD_W-1:0] coord_t;

    // Stored value that means zero and shift that divides by the amplitude
    localparam int TRIG_ZERO  = 128;
    localparam int TRIG_SHIFT = 7;

    // Stage sequencing states
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_multiply,
        st_output
    } orbit_state_e;

endpackage

// ==== trig_rom.sv ====
`timescale 1ns/1ps

module trig_rom (
    input  logic              clk,
    input  logic              rst_n,
    input  orbit_pkg::angle_t angle,
    input  logic              lookup_en,
    output orbit_pkg::trig_t  sin_val,
    output orbit_pkg::trig_t  cos_val
);

    // Steps in one quadrant, also the phase lead of cosine over sine
    localparam int QUARTER = 1 << (orbit_pkg::ANGLE_W - 2);

    // ========================================================================
    // Quarter-wave sine table, 128 + 127 * sin(2*pi*i/256) for i = 0..64
    // ========================================================================
    localparam orbit_pkg::trig_t QUARTER_SINE [0:64] = '{
        8'd128, 8'd131, 8'd134, 8'd137, 8'd140, 8'd143, 8'd146, 8'd149,
        8'd152, 8'd156, 8'd159, 8'd162, 8'd165, 8'd168, 8'd171, 8'd174,
        8'd177, 8'd179, 8'd182, 8'd185, 8'd188, 8'd191, 8'd193, 8'd196,
        8'd199, 8'd201, 8'd204, 8'd206, 8'd209, 8'd211, 8'd213, 8'd216,
        8'd218, 8'd220, 8'd222, 8'd224, 8'd226, 8'd228, 8'd230, 8'd232,
        8'd234, 8'd235, 8'd237, 8'd238, 8'd240, 8'd241, 8'd243, 8'd244,
        8'd245, 8'd246, 8'd247, 8'd248, 8'd249, 8'd250, 8'd251, 8'd252,
        8'd252, 8'd253, 8'd253, 8'd254, 8'd254, 8'd254, 8'd255, 8'd255,
        8'd255
    };

    // Full-wave sine from the quarter table by symmetry
    function automatic orbit_pkg::trig_t fold_sine(input orbit_pkg::angle_t a);
        logic [6:0]       idx;
        logic [5:0]       step;
        orbit_pkg::trig_t q;
        step = a[orbit_pkg::ANGLE_W-3:0];
        // Quadrants 1 and 3 run the table backwards
        if (a[orbit_pkg::ANGLE_W-2]) begin
            idx = 7'(QUARTER) - {1'b0, step};
        end else begin
            idx = {1'b0, step};
        end
        q = QUARTER_SINE[idx];
        // Lower half of the turn mirrors about zero
        if (a[orbit_pkg::ANGLE_W-1]) begin
            fold_sine = orbit_pkg::trig_t'(2 * orbit_pkg::TRIG_ZERO - int'(q));
        end else begin
            fold_sine = q;
        end
    endfunction

    orbit_pkg::angle_t cos_angle;
    orbit_pkg::trig_t  sin_lookup;
    orbit_pkg::trig_t  cos_lookup;

    // cos(a) = sin(a + quarter turn), wraps with the angle width
    assign cos_angle  = orbit_pkg::angle_t'(angle + QUARTER);
    assign sin_lookup = fold_sine(angle);
    assign cos_lookup = fold_sine(cos_angle);

    // ========================================================================
    // Output registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Angle zero: sine at zero, cosine at full scale
            sin_val <= orbit_pkg::trig_t'(orbit_pkg::TRIG_ZERO);
            cos_val <= '1;
        end else if (lookup_en) begin
            sin_val <= sin_lookup;
            cos_val <= cos_lookup;
        end
    end

endmodule

// ==== orbit_ctrl.sv ====
`timescale 1ns/1ps

module orbit_ctrl #(
    parameter int EMIT_PERIOD = 1024
) (
    input  logic              clk,
    input  logic              rst_n,
    output orbit_pkg::angle_t angle,
    output logic              lookup_en,
    output logic              mult_en,
    output logic              out_en
);

    localparam int CNT_W = (EMIT_PERIOD > 1) ? $clog2(EMIT_PERIOD) : 1;

    logic [CNT_W-1:0]        period_cnt;
    logic                    start;
    orbit_pkg::orbit_state_e state;
    orbit_pkg::orbit_state_e state_next;

    // ========================================================================
    // Emission timer and angle counter
    // ========================================================================
    assign start = (period_cnt == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period_cnt <= '0;
            angle      <= '0;
        end else begin
            if (period_cnt == CNT_W'(EMIT_PERIOD - 1)) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
            // New orbit position on every start cycle
            if (start) begin
                angle <= angle + 1'b1;
            end
        end
    end

    // ========================================================================
    // Stage sequencing FSM
    // ========================================================================
    always_comb begin
        state_next = state;
        case (state)
            orbit_pkg::st_idle:     if (start) state_next = orbit_pkg::st_lookup;
            orbit_pkg::st_lookup:   state_next = orbit_pkg::st_multiply;
            orbit_pkg::st_multiply: state_next = orbit_pkg::st_output;
            orbit_pkg::st_output:   state_next = orbit_pkg::st_idle;
            default:                state_next = orbit_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= orbit_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // One enable per pipeline stage
    assign lookup_en = (state == orbit_pkg::st_lookup);
    assign mult_en   = (state == orbit_pkg::st_multiply);
    assign out_en    = (state == orbit_pkg::st_output);

    // Period long enough for the pipeline, stages never overlap
    a_stage_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        (EMIT_PERIOD >= 4) && $onehot0({lookup_en, mult_en, out_en}))
        else $error("orbit_ctrl: stage enables overlap or EMIT_PERIOD below 4");

    // A new emission never starts while the previous one is in flight
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> (state == orbit_pkg::st_idle))
        else $error("orbit_ctrl: start cycle outside idle");

endmodule

// ==== orbit_scaler.sv ====
`timescale 1ns/1ps

module orbit_scaler #(
    parameter int         CENTER_X = 320,
    parameter int         CENTER_Y = 240,
    parameter logic [7:0] SEMI_A   = 8'd100,
    parameter logic [7:0] SEMI_B   = 8'd80
) (
    input  logic              clk,
    input  logic              rst_n,
    input  orbit_pkg::trig_t  sin_val,
    input  orbit_pkg::trig_t  cos_val,
    input  logic              mult_en,
    input  logic              out_en,
    output orbit_pkg::coord_t pixel_x,
    output orbit_pkg::coord_t pixel_y,
    output logic              pixel_valid
);

    // Trig values re-centred to signed, range -128..127
    logic signed [8:0]  cos_off;
    logic signed [8:0]  sin_off;
    logic signed [17:0] x_prod;
    logic signed [17:0] y_prod;
    logic signed [17:0] x_off;
    logic signed [17:0] y_off;

    assign cos_off = $signed({1'b0, cos_val}) - $signed(9'(orbit_pkg::TRIG_ZERO));
    assign sin_off = $signed({1'b0, sin_val}) - $signed(9'(orbit_pkg::TRIG_ZERO));

    // ========================================================================
    // Multiply stage
    // ========================================================================
    always_ff @(posedge clk) begin
        if (mult_en) begin
            x_prod <= cos_off * $signed({1'b0, SEMI_A});
            y_prod <= sin_off * $signed({1'b0, SEMI_B});
        end
    end

    // Divide by the table amplitude, sign kept
    assign x_off = x_prod >>> orbit_pkg::TRIG_SHIFT;
    assign y_off = y_prod >>> orbit_pkg::TRIG_SHIFT;

    // ========================================================================
    // Output stage
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_x     <= '0;
            pixel_y     <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= out_en;
            if (out_en) begin
                pixel_x <= orbit_pkg::coord_t'(CENTER_X + x_off);
                pixel_y <= orbit_pkg::coord_t'(CENTER_Y + y_off);
            end
        end
    end

    // Strobe is a single-cycle pulse, the display has no back-pressure
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |=> !pixel_valid)
        else $error("orbit_scaler: pixel_valid held for two cycles");

endmodule

// ==== orbit_spark.sv ====
`timescale 1ns/1ps

module orbit_spark #(
    parameter int         EMIT_PERIOD = 1024,
    parameter int         CENTER_X    = 320,
    parameter int         CENTER_Y    = 240,
    parameter logic [7:0] SEMI_A      = 8'd100,
    parameter logic [7:0] SEMI_B      = 8'd80
) (
    input  logic              clk,
    input  logic              rst_n,
    output orbit_pkg::coord_t pixel_x,
    output orbit_pkg::coord_t pixel_y,
    output logic              pixel_valid,
    output orbit_pkg::angle_t angle
);

    // Stage strobes
    logic lookup_en;
    logic mult_en;
    logic out_en;

    orbit_pkg::trig_t sin_val;
    orbit_pkg::trig_t cos_val;

    // ========================================================================
    // Timer, angle and sequencing
    // ========================================================================
    orbit_ctrl #(
        .EMIT_PERIOD (EMIT_PERIOD)
    ) i_orbit_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .angle     (angle),
        .lookup_en (lookup_en),
        .mult_en   (mult_en),
        .out_en    (out_en)
    );

    trig_rom i_trig_rom (
        .clk       (clk),
        .rst_n     (rst_n),
        .angle     (angle),
        .lookup_en (lookup_en),
        .sin_val   (sin_val),
        .cos_val   (cos_val)
    );

    // Ellipse scaling to screen coordinates
    orbit_scaler #(
        .CENTER_X (CENTER_X),
        .CENTER_Y (CENTER_Y),
        .SEMI_A   (SEMI_A),
        .SEMI_B   (SEMI_B)
    ) i_orbit_scaler (
        .clk         (clk),
        .rst_n       (rst_n),
        .sin_val     (sin_val),
        .cos_val     (cos_val),
        .mult_en     (mult_en),
        .out_en      (out_en),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid)
    );

endmodule

// ==== tb_orbit_spark.sv ====
`timescale 1ns/1ps

module tb_orbit_spark;

    localparam int EMIT_PERIOD     = 16;
    localparam int CENTER_X        = 320;
    localparam int CENTER_Y        = 240;
    localparam int SEMI_A          = 100;
    localparam int SEMI_B          = 80;
    // First strobe follows the start cycle by three stages
    localparam int RESET_TO_STROBE = 4;
    localparam int STROBE_TIMEOUT  = 4 * EMIT_PERIOD;
    localparam int ANGLE_STEPS     = 256;

    logic              clk;
    logic              rst_n;
    orbit_pkg::coord_t pixel_x;
    orbit_pkg::coord_t pixel_y;
    logic              pixel_valid;
    orbit_pkg::angle_t angle;

    int                next_gap;
    int                rows_checked;
    orbit_pkg::angle_t expected_angle;

    orbit_spark #(
        .EMIT_PERIOD (EMIT_PERIOD)
    ) i_orbit_spark (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_valid (pixel_valid),
        .angle       (angle)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================================================
    // Failure handling and value checks
    // ========================================================================
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // Hold reset low, release it and check the idle state right after
    task automatic apply_reset(input int cycles);
        int i;
        @(posedge clk);
        rst_n <= 1'b0;
        // The strobe before this reset lasted a single cycle
        @(negedge clk);
        check_value("pixel_valid", pixel_valid, 1'b0);
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pixel_valid", pixel_valid, 1'b0);
        check_value("angle", angle, 8'd0);
        check_value("pixel_x", pixel_x, 10'd0);
        check_value("pixel_y", pixel_y, 10'd0);
        next_gap       = RESET_TO_STROBE;
        expected_angle = 8'd1;
    endtask

    // ========================================================================
    // Strobe tracking
    // ========================================================================
    // Next strobe on a falling edge with its timing, angle and range
    task automatic wait_strobe();
        int clocks;
        @(negedge clk);
        clocks = 1;
        while (pixel_valid !== 1'b1 && clocks < STROBE_TIMEOUT) begin
            @(negedge clk);
            clocks = clocks + 1;
        end
        if (pixel_valid !== 1'b1) begin
            $display("Timeout: no pixel_valid strobe within %0d clocks", STROBE_TIMEOUT);
            abort_run();
        end
        // A strobe held high shows up here as a gap of one clock
        check_value("strobe_gap", clocks, next_gap);
        check_value("angle", angle, expected_angle);
        // Every strobe stays inside the bounding box of the ellipse
        if (pixel_x < CENTER_X - SEMI_A || pixel_x > CENTER_X + SEMI_A) begin
            $display("Pixel out of range: pixel_x 0x%0h at angle 0x%0h", pixel_x, angle);
            abort_run();
        end
        if (pixel_y < CENTER_Y - SEMI_B || pixel_y > CENTER_Y + SEMI_B) begin
            $display("Pixel out of range: pixel_y 0x%0h at angle 0x%0h", pixel_y, angle);
            abort_run();
        end
        expected_angle = expected_angle + 1'b1;
        next_gap       = EMIT_PERIOD;
    endtask

    // Follow the strobes up to the given angle and compare its pixel
    task automatic check_golden_pixel(input int target, input int exp_x, input int exp_y);
        int strobes;
        wait_strobe();
        strobes = 1;
        while (angle !== orbit_pkg::angle_t'(target) && strobes < ANGLE_STEPS) begin
            wait_strobe();
            strobes = strobes + 1;
        end
        if (angle !== orbit_pkg::angle_t'(target)) begin
            $display("No strobe carried angle %0d within one full turn", target);
            abort_run();
        end
        check_value("pixel_x", pixel_x, exp_x);
        check_value("pixel_y", pixel_y, exp_y);
        rows_checked = rows_checked + 1;
    endtask

    // ========================================================================
    // Golden file sequencer
    // ========================================================================
    initial begin
        int                fd;
        int                code;
        logic [7:0]        kind;
        int                arg_a;
        int                arg_b;
        int                arg_c;
        logic [8*160-1:0]  rest;
        logic              done;

        rst_n          = 1'b0;
        rows_checked   = 0;
        next_gap       = RESET_TO_STROBE;
        expected_angle = 8'd1;

        fd = $fopen("orbit_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open orbit_golden.txt for reading");
            abort_run();
        end

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                // Skip the rest of a comment line
                code = $fgets(rest, fd);
            end else if (kind == "R") begin
                code = $fscanf(fd, "%d", arg_a);
                if (code != 1) begin
                    $display("Golden file has a reset row without a cycle count");
                    abort_run();
                end
                apply_reset(arg_a);
            end else if (kind == "P") begin
                code = $fscanf(fd, "%d %d %d", arg_a, arg_b, arg_c);
                if (code != 3) begin
                    $display("Golden file has a pixel row without angle, x and y");
                    abort_run();
                end
                check_golden_pixel(arg_a, arg_b, arg_c);
            end else begin
                $display("Golden file has a row of unknown type '%c'", kind);
                abort_run();
            end
        end
        $fclose(fd);

        // The last strobe of the run lasted a single cycle
        @(negedge clk);
        check_value("pixel_valid", pixel_valid, 1'b0);

        if (rows_checked != 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Golden file held no pixel rows to check");
            abort_run();
        end
    end

endmodule

// ==== orbit_golden.txt ====
# R n     : hold reset low for n clock cycles
# P a x y : expected strobe for angle a with pixel_x x and pixel_y y, decimal
R 4
P 4 418 247
P 8 416 255
P 12 414 263
P 16 411 270
P 20 407 277
P 24 402 284
P 28 396 290
P 32 390 296
P 36 383 301
P 40 375 306
P 44 366 310
P 48 358 313
P 52 348 315
P 56 338 317
P 60 329 318
P 64 320 319
P 68 310 318
P 72 301 317
P 76 291 315
P 80 281 313
P 84 273 310
P 88 264 306
P 92 256 301
P 96 249 296
P 100 243 290
P 104 237 284
P 108 232 277
P 112 228 270
P 116 225 263
P 120 223 255
P 124 221 247
P 128 220 240
P 132 221 232
P 136 223 225
P 140 225 216
P 144 228 209
P 148 232 202
P 152 237 195
P 156 243 189
P 160 249 183
P 164 256 178
P 168 264 173
P 172 273 170
P 176 281 166
P 180 291 164
P 184 301 162
P 188 310 161
P 192 320 160
P 196 329 161
P 200 338 162
P 204 348 164
P 208 358 166
P 212 366 170
P 216 375 173
P 220 383 178
P 224 390 183
P 228 396 189
P 232 402 195
P 236 407 202
P 240 411 209
P 244 414 216
P 248 416 225
P 252 418 232
P 0 419 240
R 4
P 1 419 241
P 2 419 243
P 3 418 245
P 4 418 247

// ==== vlog.f ====
orbit_pkg.sv
trig_rom.sv
orbit_ctrl.sv
orbit_scaler.sv
orbit_spark.sv
tb_orbit_spark.sv

// ==== Bender.yml ====
package:
  name: orbit_spark

sources:
  - orbit_pkg.sv
  - trig_rom.sv
  - orbit_ctrl.sv
  - orbit_scaler.sv
  - orbit_spark.sv
  - target: test
    files:
      - tb_orbit_spark.sv

# Testbench reads orbit_golden.txt from the project root
